// File: sim.f
+incdir+.
shiftPkg.sv
opLink.sv
opIssue.sv
opQueue.sv
shiftUnit.sv
shifterTop.sv
tbShifter.sv

// File: runSim.sh
#!/bin/sh
# Build the shifter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tbShifter -f sim.f -o simShifter \
	|| exit 1
output=$(./obj_dir/simShifter 2>&1)
echo "$output"
# Pass only when the pass message shows up
echo "$output" | grep -q "Everything OK" && exit 0 || exit 1

// File: tbShiftModel.svh
`ifndef TB_SHIFT_MODEL_SVH
`define TB_SHIFT_MODEL_SVH

////////////////////////////////////////
// L_shl reference model
////////////////////////////////////////

shiftRes_t expQ[$];  // Expected results, oldest first

// Value and overflow for one request, straight from the operator rules
function automatic shiftRes_t shiftModel(input logic [31:0] var1,
	input logic signed [15:0] numShift);
	shiftRes_t res;
	logic signed [31:0] v;
	int mag;
	int i;
	v = var1;
	res = '{value: var1, overflow: 1'b0};  // Zero count or zero value
	if ((numShift > 0) && (v != 0))
	begin
		// One doubling per step, clamp once the next one would not fit
		for (i = 0; i < numShift; i++)
		begin
			if (v > $signed(IN_MAX))
			begin
				res = '{value: OUT_MAX, overflow: 1'b1};
				return res;
			end
			if (v < $signed(IN_MIN))
			begin
				res = '{value: OUT_MIN, overflow: 1'b1};
				return res;
			end
			v = v * 2;
		end
		res.value = v;
	end
	else if ((numShift < 0) && (v != 0))
	begin
		mag = -int'(numShift);  // -32768 becomes 32768
		if (mag >= int'(SIGN_FILL_SHIFT))
			res.value = {32{v[31]}};  // Only sign left
		else
			res.value = v >>> mag;
	end
	return res;
endfunction

// Queue helpers
task automatic pushExpected(input logic [31:0] var1, input logic [15:0] numShift);
	expQ.push_back(shiftModel(var1, numShift));
endtask

task automatic popExpected(output shiftRes_t expected);
	expected = expQ.pop_front();
endtask

`endif

// File: tbShifter.sv
`timescale 1ns/1ps

module tbShifter
	import shiftPkg::*;
();

	localparam int QUEUE_DEPTH = 4;
	localparam int NUM_REQ = 300;                // Random requests
	localparam int BURST_REQ = QUEUE_DEPTH + 1;  // Queue slots plus the one in the unit
	localparam int CLK_PERIOD = 20;

	logic clk;
	logic reset;
	logic inValid;
	logic [31:0] inVar1;
	logic [15:0] inShift;
	logic inReady;
	logic resValid;
	logic [31:0] resValue;
	logic resOverflow;

	integer seed;
	int sent = 0;      // Accepted transfers

	`include "tbShiftModel.svh"

	shifterTop #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVar1(inVar1),
		.inShift(inShift),
		.inReady(inReady),
		.resValid(resValid),
		.resValue(resValue),
		.resOverflow(resOverflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic stopRun();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			stopRun();
		end
	endtask

	// Weighted operand classes
	task automatic pickOperands(output logic [31:0] v, output logic [15:0] s);
		int cls;
		cls = $unsigned($random(seed)) % 10;
		v = $random(seed);
		case (cls)
			0, 1: s = 16'($unsigned($random(seed)) % 8);          // Small left
			2: s = 16'(8 + $unsigned($random(seed)) % 40);        // Large left that mostly clamps
			3: s = 16'(-(1 + int'($unsigned($random(seed)) % 40))); // Right shift
			4: s = 16'h8000;                                      // Most negative count
			5: s = 16'd0;
			6:
			begin
				v = 32'd0;
				s = 16'($random(seed));  // Any count ends at once
			end
			7:
			begin
				v = IN_MAX - 32'd2 + ($unsigned($random(seed)) % 4);  // Around 3fffffff
				s = 16'(1 + $unsigned($random(seed)) % 3);
			end
			8:
			begin
				v = IN_MIN - 32'd1 + ($unsigned($random(seed)) % 4);  // Around c0000000
				s = 16'(1 + $unsigned($random(seed)) % 3);
			end
			default:
			begin
				v = $random(seed) >>> 20;  // Small signed value that never overflows
				s = 16'(1 + $unsigned($random(seed)) % 10);
			end
		endcase
	endtask

	// Offer random requests until the target count is accepted
	task automatic driveRandom(input int target);
		logic [31:0] v;
		logic [15:0] s;
		while (sent < target)
		begin
			pickOperands(v, s);
			inVar1 = v;
			inShift = s;
			inValid = ($unsigned($random(seed)) % 4) != 0;  // Gap about one in four
			@(posedge clk);
			#2;
		end
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0)
		begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);  // Unit back to idle
		#2;
	endtask

	// Back-to-back slow requests until credits run out
	task automatic fillQueue();
		int startCount;
		int lowCount;
		startCount = sent;
		inVar1 = 32'h1;
		inShift = 16'd20;  // Long enough to keep the unit busy
		inValid = 1'b1;
		while (inReady)
		begin
			@(posedge clk);
			#2;
		end
		checkValue("burstTransfers", sent - startCount, BURST_REQ);
		lowCount = sent;
		repeat (10)
		begin
			@(posedge clk);
			#2;
		end
		checkValue("stalledTransfers", sent - lowCount, 0);  // Nothing slips in
		checkValue("inReady", inReady, 0);
		inValid = 1'b0;
	endtask

	////////////////////////////////////////
	// Monitor
	////////////////////////////////////////

	always @(posedge clk)
	begin
		shiftRes_t expected;
		if (!reset && inValid && inReady)
		begin
			pushExpected(inVar1, inShift);
			sent = sent + 1;
		end
		if (!reset && resValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("Result pulse arrived with no request outstanding");
				stopRun();
			end
			else
			begin
				popExpected(expected);
				checkValue("resValue", resValue, expected.value);
				checkValue("resOverflow", resOverflow, expected.overflow);
			end
		end
	end

	// Watchdog budget of 40 cycles per request plus a margin
	initial
	begin
		#((NUM_REQ + BURST_REQ) * 40 * CLK_PERIOD + 500 * CLK_PERIOD);
		$display("Timeout, results did not drain in time");
		stopRun();
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		seed = 32'hde62;
		reset = 1'b1;
		inValid = 1'b0;
		inVar1 = 32'd0;
		inShift = 16'd0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		checkValue("inReady", inReady, 1);  // Full credit pool
		checkValue("resValid", resValid, 0);
		checkValue("resOverflow", resOverflow, 0);

		driveRandom(NUM_REQ);
		waitDrain();
		fillQueue();
		waitDrain();
		repeat (5) @(posedge clk);  // Catch stray pulses
		#2;

		$display("Everything OK");
		$finish;
	end

endmodule

// File: shifterTop.sv
`timescale 1ns/1ps

module shifterTop
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic reset,
	input logic inValid,         // Request offered
	input logic [31:0] inVar1,
	input logic [15:0] inShift,
	output logic inReady,        // Credit available
	output logic resValid,       // Result pulse
	output logic [31:0] resValue,
	output logic resOverflow
);

	////////////////////////////////////////
	// Internal links
	////////////////////////////////////////

	opLink issueLink();  // Issue stage to queue, credit flow
	opLink workLink();   // Queue to shift unit, show-ahead pop

	////////////////////////////////////////
	// Pipeline blocks
	////////////////////////////////////////

	// Producer
	opIssue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) issue (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVar1(inVar1),
		.inShift(inShift),
		.inReady(inReady),
		.issueLink(issueLink)
	);

	// Buffer, same depth as the credit pool
	opQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue (
		.clk(clk),
		.reset(reset),
		.issueLink(issueLink),
		.workLink(workLink)
	);

	// Consumer
	shiftUnit unit (
		.clk(clk),
		.reset(reset),
		.workLink(workLink),
		.resValid(resValid),
		.resValue(resValue),
		.resOverflow(resOverflow)
	);

endmodule

// File: shiftUnit.sv
`timescale 1ns/1ps

module shiftUnit
	import shiftPkg::*;
(
	input logic clk,
	input logic reset,
	opLink.sink workLink,
	output logic resValid,
	output logic [31:0] resValue,
	output logic resOverflow
);

	shiftState_t state;
	shiftState_t nextState;
	word_t valReg;             // Working value
	word_t nextVal;
	logic [15:0] cntReg;       // Remaining count, always a magnitude
	logic [15:0] nextCnt;
	shiftRes_t resReg;         // Held result
	shiftRes_t nextRes;
	logic resLoad;             // Update result register
	logic take;                // Pop the head entry
	logic [15:0] negShift;     // Magnitude of a negative count

	// Two's complement negate; -32768 gives 32768, still far past sign fill
	assign negShift = ~workLink.numShift + 16'd1;

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	// Working operands
	always_ff @(posedge clk)
	begin
		valReg <= nextVal;
		cntReg <= nextCnt;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			resReg.overflow <= 1'b0;  // Flag must read low after reset
		else if (resLoad)
			resReg <= nextRes;
	end

	////////////////////////////////////////
	// Next-state logic
	////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextVal = valReg;
		nextCnt = cntReg;
		nextRes = resReg;
		resLoad = 1'b0;
		take = 1'b0;

		case (state)
			IDLE:
			begin
				if (workLink.valid)
				begin
					take = 1'b1;
					nextVal = workLink.var1;
					if (workLink.numShift == '0)
					begin
						// Nothing to shift, pass straight through
						nextRes = '{value: workLink.var1, overflow: 1'b0};
						resLoad = 1'b1;
						nextState = DONE;
					end
					else if (workLink.var1 == '0)
					begin
						nextRes = '{value: '0, overflow: 1'b0};  // Zero stays zero
						resLoad = 1'b1;
						nextState = DONE;
					end
					else if (workLink.numShift[15])
					begin
						nextCnt = negShift;
						nextState = RIGHT;
					end
					else
					begin
						nextCnt = workLink.numShift;
						nextState = LEFT;
					end
				end
			end

			LEFT:
			begin
				if (!valReg[31] && (valReg > IN_MAX))
				begin
					nextRes = '{value: OUT_MAX, overflow: 1'b1};  // Clamp high
					resLoad = 1'b1;
					nextState = DONE;
				end
				else if (valReg[31] && (valReg < IN_MIN))
				begin
					// Unsigned compare is fine, both words negative
					nextRes = '{value: OUT_MIN, overflow: 1'b1};
					resLoad = 1'b1;
					nextState = DONE;
				end
				else
				begin
					nextVal = valReg << 1;       // Safe doubling
					nextCnt = cntReg - 16'd1;
					if (cntReg == 16'd1)
					begin
						nextRes = '{value: valReg << 1, overflow: 1'b0}; // Last step
						resLoad = 1'b1;
						nextState = DONE;
					end
				end
			end

			RIGHT:
			begin
				nextRes.overflow = 1'b0;
				if (cntReg >= SIGN_FILL_SHIFT)
					nextRes.value = {32{valReg[31]}};  // All sign bits
				else
					nextRes.value = $signed(valReg) >>> cntReg[4:0];
				resLoad = 1'b1;
				nextState = DONE;
			end

			DONE:
			begin
				nextState = IDLE;  // Result pulse this cycle
			end

			default:
			begin
				nextState = IDLE;
			end
		endcase
	end

	assign workLink.ack = take;

	assign resValid = (state == DONE);  // One-cycle pulse
	assign resValue = resReg.value;
	assign resOverflow = resReg.overflow;

endmodule

// File: opQueue.sv
`timescale 1ns/1ps

module opQueue
	import shiftPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic reset,
	opLink.sink issueLink,
	opLink.source workLink
);

	localparam int PW = $clog2(QUEUE_DEPTH);      // Pointer width
	localparam int CW = $clog2(QUEUE_DEPTH + 1);  // Occupancy width

	shiftReq_t mem [QUEUE_DEPTH];  // Entry storage
	logic [PW-1:0] wrPtr;
	logic [PW-1:0] rdPtr;
	logic [CW-1:0] count;          // Entries held
	logic push;
	logic pop;

	// Advance a pointer, wrapping at the last slot
	// Works for depths that are not a power of two
	function automatic logic [PW-1:0] nextPtr(input logic [PW-1:0] ptr);
		logic [PW-1:0] res;
		if (ptr == PW'(QUEUE_DEPTH - 1))
			res = '0;
		else
			res = ptr + 1'b1;
		return res;
	endfunction

	assign push = issueLink.valid;                // Producer never overruns, credits guard it
	assign pop = workLink.ack && workLink.valid;  // Consumer takes the head

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Push and pop cancel
			endcase
		end
	end

	// Storage write
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= '{var1: issueLink.var1, numShift: issueLink.numShift};
	end

	// Show-ahead head entry
	assign workLink.valid = (count != '0);
	assign workLink.var1 = mem[rdPtr].var1;
	assign workLink.numShift = mem[rdPtr].numShift;

	assign issueLink.ack = pop;  // Freed slot goes straight back as a credit

endmodule

// File: opIssue.sv
`timescale 1ns/1ps

module opIssue
	import shiftPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [31:0] inVar1,
	input logic [15:0] inShift,
	output logic inReady,
	opLink.source issueLink
);

	localparam int CW = $clog2(QUEUE_DEPTH + 1); // Counter holds 0..QUEUE_DEPTH

	logic [CW-1:0] credits;  // Free queue slots we may still claim
	logic accept;            // Request taken this cycle
	logic pushReg;           // One-cycle push toward the queue
	shiftReq_t reqReg;       // Registered operands

	assign inReady = (credits != '0);   // Ready whenever a slot is free
	assign accept = inValid && inReady;

	////////////////////////////////////////
	// Credit counter and push strobe
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credits <= CW'(QUEUE_DEPTH);  // Whole queue free
			pushReg <= 1'b0;
		end
		else
		begin
			pushReg <= accept;
			case ({accept, issueLink.ack})
				2'b10: credits <= credits - 1'b1;  // Spent one
				2'b01: credits <= credits + 1'b1;  // Queue gave one back
				default: credits <= credits;       // Both or neither
			endcase
		end
	end

	// Operand capture, no reset needed
	always_ff @(posedge clk)
	begin
		if (accept)
			reqReg <= '{var1: inVar1, numShift: inShift};
	end

	assign issueLink.valid = pushReg;
	assign issueLink.var1 = reqReg.var1;
	assign issueLink.numShift = reqReg.numShift;

endmodule

// File: opLink.sv
`timescale 1ns/1ps

// One operand stream between two design blocks
// valid goes forward with the operands, ack comes back
interface opLink
	import shiftPkg::*;
();

	logic valid;        // Push strobe or not-empty flag, depending on the link
	word_t var1;        // Operand value
	count_t numShift;   // Signed shift count
	logic ack;          // Credit return or pop strobe

	// Upstream side
	modport source
	(
		output valid,
		output var1,
		output numShift,
		input ack
	);

	// Downstream side
	modport sink
	(
		input valid,
		input var1,
		input numShift,
		output ack
	);

endinterface

// File: shiftPkg.sv
package shiftPkg;

	////////////////////////////////////////
	// Basic operand types
	////////////////////////////////////////

	typedef logic [31:0] word_t;          // 32-bit operand / result word
	typedef logic signed [15:0] count_t;  // Signed shift count

	// One shift request as it sits in the queue
	typedef struct packed
	{
		word_t var1;      // Value to shift
		count_t numShift; // Positive means left, negative means right
	} shiftReq_t;

	// One finished result
	typedef struct packed
	{
		word_t value;
		logic overflow;   // Set only when a left shift saturated
	} shiftRes_t;

	////////////////////////////////////////
	// Saturation and doubling limits
	////////////////////////////////////////

	localparam word_t OUT_MAX = 32'h7fff_ffff; // Largest positive result
	localparam word_t OUT_MIN = 32'h8000_0000; // Most negative result
	localparam word_t IN_MAX = 32'h3fff_ffff;  // Above this, doubling overflows
	localparam word_t IN_MIN = 32'hc000_0000;  // Below this, doubling underflows

	// Right shifts this far or further leave only sign bits
	localparam logic [15:0] SIGN_FILL_SHIFT = 16'd31;

	// Shift unit FSM
	typedef enum logic [1:0] {IDLE, LEFT, RIGHT, DONE} shiftState_t;

endpackage
